// File: common/rtg_defs.svh
`ifndef RTG_DEFS_SVH
`define RTG_DEFS_SVH

// ------------------------------
// Register word offsets, rs[3:1]
// ------------------------------
`define RTG_REG_BASE_HI 3'd0
`define RTG_REG_BASE_LO 3'd1
`define RTG_REG_FORMAT  3'd2
`define RTG_REG_ENABLE  3'd3
`define RTG_REG_HSIZE   3'd4
`define RTG_REG_VSIZE   3'd5
`define RTG_REG_STRIDE  3'd6
`define RTG_REG_ID      3'd7

// Address bit that selects the palette window
`define RTG_PAL_BIT     10

// ID 0x50, version 0x01
`define RTG_ID          16'h5001

// ------------------------------
// Pixel formats
// ------------------------------
`define RTG_FMT_CLUT8   5'd0
`define RTG_FMT_RGB565  5'd1
`define RTG_FMT_XRGB32  5'd2

// Palette entries
`define RTG_PAL_DEPTH   256

// Raster position to output pixel, in clocks
`define RTG_SCAN_LATENCY 3

`endif

// File: common/rtg_pkg.sv
package rtg_pkg;

	// ------------------------------
	// CPU side
	// ------------------------------

	// One bus access, as seen by the register block
	typedef struct packed {
		logic        aen;
		logic        rd;
		logic        wr;
		logic [11:0] rs;
		logic [15:0] wdata;
	} rtg_bus_t;

	// Display settings from the register block
	typedef struct packed {
		logic        ena;
		logic [4:0]  format;
		logic [31:0] base;
		logic [11:0] hsize;
		logic [11:0] vsize;
		logic [13:0] stride;
	} rtg_cfg_t;

	// Full 24-bit palette write, merged from two bus halves
	typedef struct packed {
		logic        we;
		logic [7:0]  addr;
		logic [23:0] data;
	} rtg_pal_wr_t;

	// ------------------------------
	// Scanout pipeline
	// ------------------------------

	// Raster position
	typedef struct packed {
		logic        valid;
		logic        sof;
		logic [11:0] x;
		logic [11:0] y;
	} rtg_pos_t;

	// Fetch in flight, lane is the byte offset within the word
	typedef struct packed {
		logic       valid;
		logic       sof;
		logic [4:0] format;
		logic [1:0] lane;
	} rtg_fetch_t;

	// Output pixel
	typedef struct packed {
		logic       valid;
		logic       sof;
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rtg_pix_t;

endpackage

// File: verilog/rtg_regs.sv
`timescale 1ns/1ps
`include "rtg_defs.svh"

module rtg_regs import rtg_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        clk7_en,
	input  rtg_bus_t    bus,
	output logic [15:0] rdata,
	output rtg_cfg_t    cfg,
	output rtg_pal_wr_t pal_wr,
	output logic [7:0]  pal_raddr,
	input  logic [23:0] pal_rdata
);

	// ------------------------------
	// Address decode
	// ------------------------------
	logic        access;
	logic        sel_reg;
	logic        sel_pal;
	logic        reg_we;
	logic [2:0]  word;
	// Last written halves of the palette entry
	logic [23:0] pal_hold;

	assign access  = bus.aen & (bus.rd | bus.wr);
	assign sel_pal = access & bus.rs[`RTG_PAL_BIT];
	assign sel_reg = access & ~bus.rs[`RTG_PAL_BIT];
	assign word    = bus.rs[3:1];
	// Writes land only on the slow bus enable
	assign reg_we  = sel_reg & bus.wr & clk7_en;

	// Enable is the only setting with a reset value
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg.ena <= 1'b0;
		end else if (reg_we && word == `RTG_REG_ENABLE) begin
			cfg.ena <= bus.wdata[0];
		end
	end

	// Remaining settings stay undefined until written
	always_ff @(posedge clk) begin
		if (reg_we) begin
			case (word)
				`RTG_REG_BASE_HI: cfg.base[31:16] <= bus.wdata;
				`RTG_REG_BASE_LO: cfg.base[15:0]  <= bus.wdata;
				`RTG_REG_FORMAT:  cfg.format      <= bus.wdata[4:0];
				`RTG_REG_HSIZE:   cfg.hsize       <= bus.wdata[11:0];
				`RTG_REG_VSIZE:   cfg.vsize       <= bus.wdata[11:0];
				`RTG_REG_STRIDE:  cfg.stride      <= bus.wdata[13:0];
				default: ;
			endcase
		end
	end

	// ------------------------------
	// Palette port
	// ------------------------------

	// Holding register keeps the half not written this time
	always_ff @(posedge clk) begin
		if (pal_wr.we) begin
			pal_hold <= pal_wr.data;
		end
	end

	assign pal_wr.we   = sel_pal & bus.wr & clk7_en;
	assign pal_wr.addr = bus.rs[9:2];
	// rs[1] low is red, high is green and blue
	assign pal_wr.data = bus.rs[1] ? {pal_hold[23:16], bus.wdata}
	                               : {bus.wdata[7:0], pal_hold[15:0]};
	assign pal_raddr   = bus.rs[9:2];

	// ------------------------------
	// Read mux
	// ------------------------------
	always_comb begin
		rdata = 16'h0000;
		if (sel_pal) begin
			rdata = bus.rs[1] ? pal_rdata[15:0] : {8'h00, pal_rdata[23:16]};
		end else if (sel_reg) begin
			case (word)
				`RTG_REG_BASE_HI: rdata = cfg.base[31:16];
				`RTG_REG_BASE_LO: rdata = cfg.base[15:0];
				`RTG_REG_FORMAT:  rdata = {11'h000, cfg.format};
				`RTG_REG_ENABLE:  rdata = {15'h0000, cfg.ena};
				`RTG_REG_HSIZE:   rdata = {4'h0, cfg.hsize};
				`RTG_REG_VSIZE:   rdata = {4'h0, cfg.vsize};
				`RTG_REG_STRIDE:  rdata = {2'b00, cfg.stride};
				default:          rdata = `RTG_ID;
			endcase
		end
	end

	// A palette write leaves the display settings untouched
	a_pal_keeps_cfg: assert property (@(posedge clk) disable iff (reset)
		pal_wr.we |=> cfg === $past(cfg));

	// Bus never reads and writes in one access
	a_bus_rd_wr: assert property (@(posedge clk) disable iff (reset)
		bus.aen |-> !(bus.rd && bus.wr));

endmodule

// File: verilog/rtg_clut.sv
`timescale 1ns/1ps
`include "rtg_defs.svh"

module rtg_clut import rtg_pkg::*; (
	input  logic        clk,
	input  rtg_pal_wr_t pal_wr,
	input  logic [7:0]  bus_addr,
	output logic [23:0] bus_rdata,
	input  logic [7:0]  scan_addr,
	output logic [23:0] scan_data
);

	// ------------------------------
	// Palette storage, RGB per entry
	// ------------------------------
	logic [23:0] mem [`RTG_PAL_DEPTH];

	// Bus side is the only writer
	always_ff @(posedge clk) begin
		if (pal_wr.we) begin
			mem[pal_wr.addr] <= pal_wr.data;
		end
	end

	// CPU readback, same cycle
	assign bus_rdata = mem[bus_addr];

	// Scan side, one clock behind the address
	always_ff @(posedge clk) begin
		scan_data <= mem[scan_addr];
	end

endmodule

// File: scanout/rtg_raster.sv
`timescale 1ns/1ps

module rtg_raster import rtg_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  rtg_cfg_t cfg,
	output rtg_pos_t pos
);

	// Next position to emit
	logic [11:0] x_cnt;
	logic [11:0] y_cnt;
	logic        run;
	logic        x_last;
	logic        y_last;

	// Zero sized frame emits nothing
	assign run    = cfg.ena && cfg.hsize != 12'd0 && cfg.vsize != 12'd0;
	assign x_last = x_cnt >= cfg.hsize - 12'd1;
	assign y_last = y_cnt >= cfg.vsize - 12'd1;

	// ------------------------------
	// Position counter
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset || !run) begin
			// Disabled raster parks at the origin
			x_cnt     <= 12'd0;
			y_cnt     <= 12'd0;
			pos.valid <= 1'b0;
			pos.sof   <= 1'b0;
		end else begin
			pos.valid <= 1'b1;
			pos.sof   <= x_cnt == 12'd0 && y_cnt == 12'd0;
			if (x_last) begin
				x_cnt <= 12'd0;
				// Wrap to the top after the last line
				y_cnt <= y_last ? 12'd0 : y_cnt + 12'd1;
			end else begin
				x_cnt <= x_cnt + 12'd1;
			end
		end
	end

	// Coordinates need no reset, valid qualifies them
	always_ff @(posedge clk) begin
		pos.x <= x_cnt;
		pos.y <= y_cnt;
	end

	// Emitted column always inside the line
	a_x_in_line: assert property (@(posedge clk) disable iff (reset)
		pos.valid |-> pos.x < cfg.hsize);

endmodule

// File: scanout/rtg_fetch.sv
`timescale 1ns/1ps
`include "rtg_defs.svh"

module rtg_fetch import rtg_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  rtg_cfg_t    cfg,
	input  rtg_pos_t    pos,
	output logic [31:0] fb_addr,
	output logic        fb_rd,
	output rtg_fetch_t  fetch
);

	// ------------------------------
	// Byte address of the pixel
	// ------------------------------
	logic [1:0]  bpp_shift;
	logic [31:0] line_off;
	logic [31:0] pix_off;
	logic [31:0] byte_addr;

	// Log2 of bytes per pixel
	always_comb begin
		case (cfg.format)
			`RTG_FMT_CLUT8:  bpp_shift = 2'd0;
			`RTG_FMT_RGB565: bpp_shift = 2'd1;
			// xRGB32, and unknown codes still fetch a full word
			default:         bpp_shift = 2'd2;
		endcase
	end

	assign line_off  = 32'(pos.y) * 32'(cfg.stride);
	assign pix_off   = 32'(pos.x) << bpp_shift;
	assign byte_addr = cfg.base + line_off + pix_off;

	// ------------------------------
	// Read strobe and tag
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			fb_rd       <= 1'b0;
			fetch.valid <= 1'b0;
		end else begin
			fb_rd       <= pos.valid;
			fetch.valid <= pos.valid;
		end
	end

	// Word aligned address, low bits ride along as the lane
	always_ff @(posedge clk) begin
		fb_addr      <= {byte_addr[31:2], 2'b00};
		fetch.lane   <= byte_addr[1:0];
		fetch.format <= cfg.format;
		fetch.sof    <= pos.sof;
	end

endmodule

// File: scanout/rtg_pixel.sv
`timescale 1ns/1ps
`include "rtg_defs.svh"

module rtg_pixel import rtg_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  rtg_fetch_t  fetch,
	input  logic [31:0] fb_rdata,
	output logic [7:0]  scan_addr,
	input  logic [23:0] scan_data,
	output rtg_pix_t    pix
);

	// Tag aligned with the returning memory word
	rtg_fetch_t  tag;
	logic [7:0]  lane_byte;
	logic [15:0] lane_half;
	logic        is_clut;
	logic [23:0] colour;
	// Second stage
	logic        pv_valid;
	logic        pv_sof;
	logic        pv_clut;
	logic [23:0] pv_colour;

	// ------------------------------
	// Stage 3, data return
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			tag.valid <= 1'b0;
		end else begin
			tag.valid <= fetch.valid;
		end
	end

	always_ff @(posedge clk) begin
		tag.sof    <= fetch.sof;
		tag.format <= fetch.format;
		tag.lane   <= fetch.lane;
	end

	// Little-endian lanes
	assign lane_byte = fb_rdata[8 * tag.lane +: 8];
	assign lane_half = tag.lane[1] ? fb_rdata[31:16] : fb_rdata[15:0];

	// Index goes straight to the palette scan port
	assign scan_addr = lane_byte;
	assign is_clut   = tag.format == `RTG_FMT_CLUT8;

	// Direct colour formats
	always_comb begin
		case (tag.format)
			`RTG_FMT_RGB565: begin
				// Replicate high bits into the low end
				colour = {lane_half[15:11], lane_half[15:13],
				          lane_half[10:5],  lane_half[10:9],
				          lane_half[4:0],   lane_half[4:2]};
			end
			// Blue in byte 0, top byte unused
			`RTG_FMT_XRGB32: colour = fb_rdata[23:0];
			// CLUT8 colour comes from the palette, unknown is black
			default:         colour = 24'h000000;
		endcase
	end

	// ------------------------------
	// Stage 4, palette or direct
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			pv_valid <= 1'b0;
		end else begin
			pv_valid <= tag.valid;
		end
	end

	always_ff @(posedge clk) begin
		pv_sof    <= tag.sof;
		pv_clut   <= is_clut;
		pv_colour <= colour;
	end

	// scan_data lands on the same edge as pv_colour
	assign pix.valid            = pv_valid;
	assign pix.sof              = pv_sof;
	assign {pix.r, pix.g, pix.b} = pv_clut ? scan_data : pv_colour;

endmodule

// File: verilog/rtg_top.sv
`timescale 1ns/1ps

module rtg_top import rtg_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        clk7_en,
	input  rtg_bus_t    bus,
	output logic [15:0] rdata,
	output logic [31:0] fb_addr,
	output logic        fb_rd,
	input  logic [31:0] fb_rdata,
	output rtg_pix_t    pix
);

	// ------------------------------
	// Internal nets
	// ------------------------------
	rtg_cfg_t    cfg;
	rtg_pal_wr_t pal_wr;
	logic [7:0]  pal_raddr;
	logic [23:0] pal_rdata;
	rtg_pos_t    pos;
	rtg_fetch_t  fetch;
	logic [7:0]  scan_addr;
	logic [23:0] scan_data;

	// CPU registers and palette
	rtg_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.clk7_en   (clk7_en),
		.bus       (bus),
		.rdata     (rdata),
		.cfg       (cfg),
		.pal_wr    (pal_wr),
		.pal_raddr (pal_raddr),
		.pal_rdata (pal_rdata)
	);

	rtg_clut u_clut (
		.clk       (clk),
		.pal_wr    (pal_wr),
		.bus_addr  (pal_raddr),
		.bus_rdata (pal_rdata),
		.scan_addr (scan_addr),
		.scan_data (scan_data)
	);

	// Scanout stages at one pixel per clock
	rtg_raster u_raster (
		.clk   (clk),
		.reset (reset),
		.cfg   (cfg),
		.pos   (pos)
	);

	rtg_fetch u_fetch (
		.clk     (clk),
		.reset   (reset),
		.cfg     (cfg),
		.pos     (pos),
		.fb_addr (fb_addr),
		.fb_rd   (fb_rd),
		.fetch   (fetch)
	);

	rtg_pixel u_pixel (
		.clk       (clk),
		.reset     (reset),
		.fetch     (fetch),
		.fb_rdata  (fb_rdata),
		.scan_addr (scan_addr),
		.scan_data (scan_data),
		.pix       (pix)
	);

endmodule

// File: tests/tb_rtg_top.sv
`timescale 1ns/1ps
`include "rtg_defs.svh"

module tb_rtg_top import rtg_pkg::*; ();

	// ------------------------------
	// Run limits
	// ------------------------------
	// Pixels over all scanout frames, restart included
	localparam int FRAME_SUM = 24 + 8 + 8 + 8 + 8;
	localparam int TIMEOUT   = 2 * FRAME_SUM + 2000;
	localparam int PAL_USED  = 64;

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic        clk7_en = 1'b0;
	rtg_bus_t    bus = '0;
	logic [15:0] rdata;
	logic [31:0] fb_addr;
	logic        fb_rd;
	logic [31:0] fb_rdata = 32'h0;
	rtg_pix_t    pix;

	// Framebuffer bytes, palette shadow, captured results
	logic [7:0]  fb_mem [4096];
	logic [23:0] pal_shadow [`RTG_PAL_DEPTH];
	rtg_pix_t    pix_q [$];
	logic [31:0] addr_q [$];
	logic [31:0] lcg_state = 32'h64fb6037;
	logic        rd_hit;
	logic [31:0] rd_word;
	int          cycle_count = 0;
	int          err_count = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	rtg_top uut (
		.clk      (clk),
		.reset    (reset),
		.clk7_en  (clk7_en),
		.bus      (bus),
		.rdata    (rdata),
		.fb_addr  (fb_addr),
		.fb_rd    (fb_rd),
		.fb_rdata (fb_rdata),
		.pix      (pix)
	);

	always #4 clk = ~clk;

	// Slow bus enable, every other cycle
	always @(posedge clk) begin
		#1;
		clk7_en = ~clk7_en;
	end

	// Memory answers one cycle after the strobe
	always @(posedge clk) begin
		rd_hit  = fb_rd;
		rd_word = {fb_mem[{fb_addr[11:2], 2'd3}], fb_mem[{fb_addr[11:2], 2'd2}],
		           fb_mem[{fb_addr[11:2], 2'd1}], fb_mem[{fb_addr[11:2], 2'd0}]};
		#1;
		if (rd_hit) begin
			fb_rdata = rd_word;
		end
	end

	// Results in arrival order
	always @(posedge clk) begin
		if (!reset && pix.valid) begin
			pix_q.push_back(pix);
		end
		if (!reset && fb_rd) begin
			addr_q.push_back(fb_addr);
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT) begin
			$display("Run stopped after %0d cycles, the DUT did not deliver", cycle_count);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [11:0] reg_rs(input logic [2:0] word);
		return {8'h00, word, 1'b0};
	endfunction

	// Bit 10 opens the palette window, bit 1 picks the half
	function automatic logic [11:0] pal_rs(input logic [7:0] entry, input logic half);
		return {1'b0, 1'b1, entry, half, 1'b0};
	endfunction

	function automatic int bytes_per_pixel(input logic [4:0] fmt);
		case (fmt)
			`RTG_FMT_CLUT8:  return 1;
			`RTG_FMT_RGB565: return 2;
			`RTG_FMT_XRGB32: return 4;
			default:         return 0;
		endcase
	endfunction

	// Reference pixel straight from memory and palette shadow
	function automatic rtg_pix_t expected_pix(input logic [4:0] fmt, input logic [31:0] base,
		input int stride, input int x, input int y);
		rtg_pix_t    p;
		logic [31:0] a;
		logic [15:0] h;
		a = base + 32'(y * stride) + 32'(x * bytes_per_pixel(fmt));
		h = {fb_mem[a[11:0] + 12'd1], fb_mem[a[11:0]]};
		p = '0;
		p.valid = 1'b1;
		p.sof   = x == 0 && y == 0;
		case (fmt)
			`RTG_FMT_CLUT8: {p.r, p.g, p.b} = pal_shadow[fb_mem[a[11:0]]];
			`RTG_FMT_RGB565: begin
				p.r = {h[15:11], h[15:13]};
				p.g = {h[10:5], h[10:9]};
				p.b = {h[4:0], h[4:2]};
			end
			`RTG_FMT_XRGB32: begin
				p.b = fb_mem[a[11:0]];
				p.g = fb_mem[a[11:0] + 12'd1];
				p.r = fb_mem[a[11:0] + 12'd2];
			end
			default: ;
		endcase
		return p;
	endfunction

	// Mask keeps CLUT indices inside the written palette range
	task automatic fill_fb(input logic [7:0] mask);
		int i;
		for (i = 0; i < 4096; i++) begin
			fb_mem[i] = lcg_next() >> 16 & mask;
		end
	endtask

	// ------------------------------
	// Compare tasks
	// ------------------------------
	task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_pix(input string name, input rtg_pix_t exp, input rtg_pix_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_addr(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			err_count++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (err_count == errs_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, err_count - errs_before);
		end
	endtask

	// ------------------------------
	// Bus access
	// ------------------------------
	// Held until an edge where the slow enable is high
	task automatic bus_write(input logic [11:0] rs, input logic [15:0] data);
		logic hit;
		bus = '{aen: 1'b1, rd: 1'b0, wr: 1'b1, rs: rs, wdata: data};
		hit = 1'b0;
		while (!hit) begin
			@(posedge clk);
			hit = clk7_en;
		end
		#1;
		bus = '0;
	endtask

	task automatic bus_read(input logic [11:0] rs, output logic [15:0] value);
		bus = '{aen: 1'b1, rd: 1'b1, wr: 1'b0, rs: rs, wdata: 16'h0};
		@(posedge clk);
		value = rdata;
		#1;
		bus = '0;
	endtask

	// ------------------------------
	// Scanout helpers
	// ------------------------------
	task automatic start_frame(input logic [4:0] fmt, input logic [31:0] base,
		input int hs, input int vs, input int stride);
		bus_write(reg_rs(`RTG_REG_ENABLE), 16'h0000);
		// Let positions in flight drain
		repeat (`RTG_SCAN_LATENCY + 2) @(posedge clk);
		#1;
		pix_q.delete();
		addr_q.delete();
		bus_write(reg_rs(`RTG_REG_BASE_HI), base[31:16]);
		bus_write(reg_rs(`RTG_REG_BASE_LO), base[15:0]);
		bus_write(reg_rs(`RTG_REG_FORMAT), {11'h0, fmt});
		bus_write(reg_rs(`RTG_REG_HSIZE), 16'(hs));
		bus_write(reg_rs(`RTG_REG_VSIZE), 16'(vs));
		bus_write(reg_rs(`RTG_REG_STRIDE), 16'(stride));
		bus_write(reg_rs(`RTG_REG_ENABLE), 16'h0001);
	endtask

	// One full frame plus the first pixel of the next
	task automatic check_frame(input string name, input logic [4:0] fmt,
		input logic [31:0] base, input int hs, input int vs, input int stride);
		int          n;
		int          i;
		logic [31:0] a;
		n = hs * vs;
		while (pix_q.size() < n + 1) begin
			@(posedge clk);
		end
		#1;
		for (i = 0; i < n; i++) begin
			check_pix(name, expected_pix(fmt, base, stride, i % hs, i / hs), pix_q[i]);
		end
		if (!pix_q[n].sof) begin
			$display("%s: next frame did not start after %0d pixels", name, n);
			err_count++;
		end
		if (bytes_per_pixel(fmt) != 0) begin
			for (i = 0; i < n; i++) begin
				a = base + 32'((i / hs) * stride) + 32'((i % hs) * bytes_per_pixel(fmt));
				check_addr(name, {a[31:2], 2'b00}, addr_q[i]);
			end
		end
	endtask

	// ------------------------------
	// Directed tests
	// ------------------------------
	task automatic test_regs();
		int          e;
		logic [15:0] v;
		e = err_count;
		bus_read(reg_rs(`RTG_REG_ENABLE), v);
		check_word("regs", 16'h0000, v);
		bus_read(reg_rs(`RTG_REG_ID), v);
		check_word("regs", `RTG_ID, v);
		bus_write(reg_rs(`RTG_REG_BASE_HI), 16'h1234);
		bus_write(reg_rs(`RTG_REG_BASE_LO), 16'hbeef);
		bus_write(reg_rs(`RTG_REG_FORMAT), 16'hffe3);
		bus_write(reg_rs(`RTG_REG_HSIZE), 16'hf123);
		bus_write(reg_rs(`RTG_REG_VSIZE), 16'hf456);
		bus_write(reg_rs(`RTG_REG_STRIDE), 16'hffff);
		bus_read(reg_rs(`RTG_REG_BASE_HI), v);
		check_word("regs", 16'h1234, v);
		bus_read(reg_rs(`RTG_REG_BASE_LO), v);
		check_word("regs", 16'hbeef, v);
		// Fields narrower than the bus word
		bus_read(reg_rs(`RTG_REG_FORMAT), v);
		check_word("regs", 16'hffe3 & 16'h001f, v);
		bus_read(reg_rs(`RTG_REG_HSIZE), v);
		check_word("regs", 16'hf123 & 16'h0fff, v);
		bus_read(reg_rs(`RTG_REG_VSIZE), v);
		check_word("regs", 16'hf456 & 16'h0fff, v);
		bus_read(reg_rs(`RTG_REG_STRIDE), v);
		check_word("regs", 16'hffff & 16'h3fff, v);
		finish_test("regs", e);
	endtask

	task automatic test_palette();
		int          e;
		int          i;
		logic [31:0] r;
		logic [15:0] v;
		e = err_count;
		for (i = 0; i < PAL_USED; i++) begin
			r = lcg_next();
			pal_shadow[i] = r[23:0];
			// Junk in the upper byte of the red write
			bus_write(pal_rs(8'(i), 1'b0), {r[31:24], r[23:16]});
			bus_write(pal_rs(8'(i), 1'b1), r[15:0]);
		end
		for (i = 0; i < PAL_USED; i++) begin
			bus_read(pal_rs(8'(i), 1'b0), v);
			check_word("palette", {8'h00, pal_shadow[i][23:16]}, v);
			bus_read(pal_rs(8'(i), 1'b1), v);
			check_word("palette", pal_shadow[i][15:0], v);
		end
		finish_test("palette", e);
	endtask

	task automatic test_clut8();
		int e;
		e = err_count;
		fill_fb(8'(PAL_USED - 1));
		start_frame(`RTG_FMT_CLUT8, 32'h0000_0104, 8, 3, 12);
		check_frame("clut8", `RTG_FMT_CLUT8, 32'h0000_0104, 8, 3, 12);
		finish_test("clut8", e);
	endtask

	task automatic test_direct();
		int e;
		e = err_count;
		fill_fb(8'hff);
		start_frame(`RTG_FMT_RGB565, 32'h0000_0202, 4, 2, 16);
		check_frame("rgb565", `RTG_FMT_RGB565, 32'h0000_0202, 4, 2, 16);
		start_frame(`RTG_FMT_XRGB32, 32'h0000_0300, 4, 2, 20);
		check_frame("xrgb32", `RTG_FMT_XRGB32, 32'h0000_0300, 4, 2, 20);
		finish_test("rgb565 and xrgb32", e);
	endtask

	task automatic test_disable();
		int   e;
		int   i;
		logic stopped;
		e = err_count;
		start_frame(5'd5, 32'h0000_0400, 4, 2, 16);
		check_frame("unknown format", 5'd5, 32'h0000_0400, 4, 2, 16);
		bus_write(reg_rs(`RTG_REG_ENABLE), 16'h0000);
		// Last positions still in the pipe
		repeat (`RTG_SCAN_LATENCY + 1) @(posedge clk);
		stopped = 1'b1;
		for (i = 0; i < 8; i++) begin
			@(posedge clk);
			if (pix.valid) begin
				stopped = 1'b0;
			end
		end
		#1;
		if (!stopped) begin
			$display("disable: pixels still valid after the enable was cleared");
			err_count++;
		end
		// Restart from the origin
		bus_write(reg_rs(`RTG_REG_FORMAT), {11'h0, `RTG_FMT_XRGB32});
		pix_q.delete();
		addr_q.delete();
		bus_write(reg_rs(`RTG_REG_ENABLE), 16'h0001);
		check_frame("restart", `RTG_FMT_XRGB32, 32'h0000_0400, 4, 2, 16);
		finish_test("disable and unknown format", e);
	endtask

	// ------------------------------
	// Sequence
	// ------------------------------
	initial begin
		fill_fb(8'hff);
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		test_regs();
		test_palette();
		test_clut8();
		test_direct();
		test_disable();
		$display("Tests run %0d, tests failed %0d, errors %0d",
		         tests_run, tests_failed, err_count);
		if (err_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: rtg_top.f
+incdir+common
common/rtg_pkg.sv
verilog/rtg_regs.sv
verilog/rtg_clut.sv
scanout/rtg_raster.sv
scanout/rtg_fetch.sv
scanout/rtg_pixel.sv
verilog/rtg_top.sv
tests/tb_rtg_top.sv

// File: Bender.yml
package:
  name: rtg_top

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/rtg_pkg.sv
      - verilog/rtg_regs.sv
      - verilog/rtg_clut.sv
      - scanout/rtg_raster.sv
      - scanout/rtg_fetch.sv
      - scanout/rtg_pixel.sv
      - verilog/rtg_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_rtg_top.sv
